//--- files.f
+incdir+bench
common/la_protocol_pkg.sv
common/la_config_pkg.sv
parser/la_frame_parser.sv
parser/la_config_regs.sv
source/la_response_writer.sv
source/la_host_link.sv
bench/tb_la_host_link.sv

//--- Bender.yml
package:
  name: la_host_link

sources:
  - files:
      - common/la_protocol_pkg.sv
      - common/la_config_pkg.sv
      - parser/la_frame_parser.sv
      - parser/la_config_regs.sv
      - source/la_response_writer.sv
      - source/la_host_link.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_la_host_link.sv

//--- bench/tb_host_tasks.svh
// host frame and response helpers
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

  // one byte, strobed for a single cycle
  task automatic send_byte(input logic [7:0] b);
    @(negedge clk);
    rx_strobe = 1'b1;
    rx_data   = b;
    @(negedge clk);
    rx_strobe = 1'b0;
  endtask

  // args hold nargs ascii bytes, first byte highest
  task automatic send_frame(input logic [7:0] cmd, input logic [63:0] args, input int nargs);
    int i;
    send_byte(START_ID);
    send_byte(cmd);
    for (i = nargs - 1; i >= 0; i--) begin
      send_byte(args[8*i +: 8]);
    end
    send_byte(LINE_FEED);
  endtask

  // pops monitored bytes up to the line feed, tx_full toggles randomly when stalling
  task automatic collect_response(input bit stall, output logic [39:0] got);
    int          cycles;
    logic [7:0]  b;
    bit          seen_lf;
    got     = '0;
    cycles  = 0;
    seen_lf = 1'b0;
    while (!seen_lf && cycles < RESP_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (stall) begin
        tx_full = ($urandom % 2 == 1);
      end
      while (tx_bytes.size() > 0 && !seen_lf) begin
        b       = tx_bytes.pop_front();
        got     = {got[31:0], b};
        seen_lf = (b == LINE_FEED);
      end
    end
    tx_full = 1'b0;
    if (!seen_lf) begin
      $display("test %s: no line feed from the DUT within %0d cycles", test_name, RESP_TIMEOUT);
      errors++;
    end
  endtask

  // id, status, optional arg, CR, LF packed low aligned
  function automatic logic [39:0] expected_response(input logic [7:0] status,
                                                    input logic has_arg, input logic [7:0] arg);
    la_response_t r;
    logic [39:0]  e;
    r.status  = status;
    r.has_arg = has_arg;
    r.arg     = arg;
    e = {RESPONSE_ID, r.status};
    if (r.has_arg) begin
      e = {e[31:0], r.arg};
    end
    e = {e[23:0], CARRIAGE_RETURN, LINE_FEED};
    return e;
  endfunction

  function automatic logic [7:0] ascii_hex(input logic [3:0] n);
    return (n < 4'd10) ? (8'h30 + n) : (8'h41 + n - 8'd10);
  endfunction

  function automatic logic [63:0] hex_args(input logic [31:0] v);
    logic [63:0] a;
    int          i;
    a = '0;
    for (i = 7; i >= 0; i--) begin
      a = {a[55:0], ascii_hex(v[4*i +: 4])};
    end
    return a;
  endfunction

`endif

//--- bench/tb_la_host_link.sv
// host link testbench

module tb_la_host_link;
  timeunit 1ns;
  timeprecision 100ps;

  import la_protocol_pkg::*;
  import la_config_pkg::*;

  localparam int RESP_TIMEOUT = 200;
  localparam int QUIET_WINDOW = 20;

  logic       clk = 1'b0;
  logic       rst;
  logic       rx_strobe;
  logic [7:0] rx_data;
  logic       tx_full;
  logic       tx_strobe;
  logic [7:0] tx_data;
  logic       disable_uart;
  la_config_t settings;
  logic       set_strobe;
  logic       enable;

  logic [7:0]  tx_bytes[$];
  logic        full_q;
  int          strobe_cnt;
  int          errors;
  int          errors_at_start;
  int          tests;
  int          failed_tests;
  string       test_name;
  logic [39:0] ok_resp;
  logic [31:0] value;
  logic [31:0] old_trigger;
  int          k;
  int          cycles;

  la_host_link UUT (
    .clk          (clk),
    .rst          (rst),
    .rx_strobe    (rx_strobe),
    .rx_data      (rx_data),
    .tx_full      (tx_full),
    .tx_strobe    (tx_strobe),
    .tx_data      (tx_data),
    .disable_uart (disable_uart),
    .settings     (settings),
    .set_strobe   (set_strobe),
    .enable       (enable)
  );

  always #4 clk = ~clk;

  `include "tb_host_tasks.svh"

  // tx byte monitor and stall rule
  always @(posedge clk) begin
    full_q <= tx_full;
    if (!rst) begin
      if (tx_strobe) begin
        tx_bytes.push_back(tx_data);
        assert (!full_q) else begin
          $display("test %s: tx_strobe came right after a cycle with tx_full high", test_name);
          errors++;
        end
      end
      if (set_strobe) begin
        strobe_cnt++;
      end
    end
  end

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      $display("** Error %s %s: expected %h, got %h", test_name, what, exp, got);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == errors_at_start) begin
      $display("test %s passed", test_name);
    end else begin
      failed_tests++;
      $display("test %s failed with %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  task automatic exchange(input logic [7:0] cmd, input logic [63:0] args, input int nargs,
                          input logic [39:0] exp, input bit stall);
    logic [39:0] got;
    send_frame(cmd, args, nargs);
    collect_response(stall, got);
    check_value("response", exp, got);
  endtask

  function automatic logic [7:0] write_letter(input int idx);
    case (idx)
      0:       return CMD_WRITE_TRIGGER;
      1:       return CMD_WRITE_MASK;
      2:       return CMD_WRITE_TRIGGER_AFTER;
      3:       return CMD_WRITE_TRIGGER_EDGE;
      4:       return CMD_WRITE_BOTH_EDGES;
      default: return CMD_WRITE_REPEAT_COUNT;
    endcase
  endfunction

  function automatic logic [31:0] setting_field(input int idx);
    case (idx)
      0:       return settings.trigger;
      1:       return settings.trigger_mask;
      2:       return settings.trigger_after;
      3:       return settings.trigger_edge;
      4:       return settings.both_edges;
      default: return settings.repeat_count;
    endcase
  endfunction

  initial begin
    void'($urandom(32'h8311_3505));
    rst          = 1'b1;
    rx_strobe    = 1'b0;
    rx_data      = 8'h00;
    tx_full      = 1'b0;
    disable_uart = 1'b0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    strobe_cnt   = 0;
    ok_resp      = expected_response(RESPONSE_SUCCESS, 1'b0, 8'h00);
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    start_test("ping");
    exchange(CMD_PING, 64'h0, 0, ok_resp, 1'b0);
    end_test();

    start_test("write_settings");
    for (k = 0; k < 6; k++) begin
      // enable first so the clear on each write shows
      exchange(CMD_SET_ENABLE, 64'h31, 1, ok_resp, 1'b0);
      value      = $urandom;
      strobe_cnt = 0;
      exchange(write_letter(k), hex_args(value), 8, ok_resp, 1'b0);
      check_value("set_strobe count", 1, strobe_cnt);
      check_value("enable", 0, enable);
      check_value("setting", value, setting_field(k));
    end
    end_test();

    start_test("enable");
    exchange(CMD_SET_ENABLE, 64'h31, 1, ok_resp, 1'b0);
    exchange(CMD_GET_ENABLE, 64'h0, 0, expected_response(RESPONSE_SUCCESS, 1'b1, 8'h31), 1'b0);
    check_value("enable", 1, enable);
    exchange(CMD_SET_ENABLE, 64'h37, 1, expected_response(RESPONSE_FAIL, 1'b0, 8'h00), 1'b0);
    check_value("enable", 1, enable);
    end_test();

    start_test("disable_uart");
    check_value("enable before disable", 1, enable);
    @(negedge clk);
    disable_uart = 1'b1;
    cycles = 0;
    while (enable && cycles < 4) begin
      @(negedge clk);
      cycles++;
    end
    assert (!enable) else begin
      $display("test %s: enable stayed high after disable_uart", test_name);
      errors++;
    end
    disable_uart = 1'b0;
    end_test();

    start_test("reject_abort");
    exchange(8'h5A, 64'h0, 0, expected_response(RESPONSE_FAIL, 1'b0, 8'h00), 1'b0);
    old_trigger = settings.trigger;
    send_frame(CMD_WRITE_TRIGGER, 64'h3132, 2);
    cycles = 0;
    while (tx_bytes.size() == 0 && cycles < QUIET_WINDOW) begin
      @(negedge clk);
      cycles++;
    end
    check_value("tx bytes after abort", 0, tx_bytes.size());
    check_value("trigger", old_trigger, settings.trigger);
    exchange(CMD_PING, 64'h0, 0, ok_resp, 1'b0);
    end_test();

    start_test("tx_stall");
    exchange(CMD_PING, 64'h0, 0, ok_resp, 1'b1);
    exchange(CMD_SET_ENABLE, 64'h31, 1, ok_resp, 1'b1);
    exchange(CMD_GET_ENABLE, 64'h0, 0, expected_response(RESPONSE_SUCCESS, 1'b1, 8'h31), 1'b1);
    end_test();

    $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- source/la_host_link.sv
// logic analyzer host command link

module la_host_link (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      rx_strobe,
  input  logic [7:0]                rx_data,
  input  logic                      tx_full,
  output logic                      tx_strobe,
  output logic [7:0]                tx_data,
  input  logic                      disable_uart,
  output la_config_pkg::la_config_t settings,
  output logic                      set_strobe,
  output logic                      enable
);
  import la_protocol_pkg::*;
  import la_config_pkg::*;

  la_config_cmd_t cfg_cmd;
  la_response_t   resp;
  logic           resp_start;
  logic           resp_done;

  la_frame_parser u_parser (
    .clk        (clk),
    .rst        (rst),
    .rx_strobe  (rx_strobe),
    .rx_data    (rx_data),
    .enable     (enable),
    .resp_done  (resp_done),
    .cfg_cmd    (cfg_cmd),
    .resp_start (resp_start),
    .resp       (resp)
  );

  la_config_regs u_regs (
    .clk          (clk),
    .rst          (rst),
    .cfg_cmd      (cfg_cmd),
    .disable_uart (disable_uart),
    .settings     (settings),
    .set_strobe   (set_strobe),
    .enable       (enable)
  );

  // bytes arriving while this runs are dropped by the parser
  la_response_writer u_writer (
    .clk        (clk),
    .rst        (rst),
    .resp_start (resp_start),
    .resp       (resp),
    .tx_full    (tx_full),
    .tx_strobe  (tx_strobe),
    .tx_data    (tx_data),
    .resp_done  (resp_done)
  );

endmodule

//--- source/la_response_writer.sv
// response frame transmitter

module la_response_writer (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          resp_start,
  input  la_protocol_pkg::la_response_t resp,
  input  logic                          tx_full,
  output logic                          tx_strobe,
  output logic [7:0]                    tx_data,
  output logic                          resp_done
);
  import la_protocol_pkg::*;

  typedef enum logic [2:0] {
    W_IDLE,
    W_ID,
    W_STATUS,
    W_ARG,
    W_CR,
    W_LF
  } write_state_e;

  write_state_e  state;
  write_state_e  next_state;
  la_response_t  req;
  logic [7:0]    cur_byte;
  logic          sending;

  // the id byte may leave on the same clock that samples resp_start
  assign sending = (state != W_IDLE) || resp_start;

  always_comb begin
    cur_byte   = RESPONSE_ID;
    next_state = W_STATUS;
    case (state)
      W_STATUS: begin
        cur_byte   = req.status;
        next_state = req.has_arg ? W_ARG : W_CR;
      end
      W_ARG: begin
        cur_byte   = req.arg;
        next_state = W_CR;
      end
      W_CR: begin
        cur_byte   = CARRIAGE_RETURN;
        next_state = W_LF;
      end
      W_LF: begin
        cur_byte   = LINE_FEED;
        next_state = W_IDLE;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (state == W_IDLE && resp_start) begin
      req <= resp;
    end
    if (sending && !tx_full) begin
      tx_data <= cur_byte;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= W_IDLE;
      tx_strobe <= 1'b0;
      resp_done <= 1'b0;
    end else begin
      tx_strobe <= 1'b0;
      resp_done <= 1'b0;
      if (sending && !tx_full) begin
        tx_strobe <= 1'b1;
        state     <= next_state;
        resp_done <= (state == W_LF);
      end else if (state == W_IDLE && resp_start) begin
        // stalled before the id byte
        state <= W_ID;
      end
    end
  end

  a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
    tx_strobe |-> !$past(tx_full));

endmodule

//--- parser/la_config_regs.sv
// analyzer setting registers

module la_config_regs (
  input  logic                          clk,
  input  logic                          rst,
  input  la_config_pkg::la_config_cmd_t cfg_cmd,
  input  logic                          disable_uart,
  output la_config_pkg::la_config_t     settings,
  output logic                          set_strobe,
  output logic                          enable
);
  import la_config_pkg::*;

  // digits collect here so an aborted frame leaves the settings alone
  logic [CFG_WIDTH-1:0] stage;
  logic [CFG_WIDTH-1:0] word;

  assign word = {stage[CFG_WIDTH-5:0], cfg_cmd.nibble};

  always_ff @(posedge clk) begin
    if (cfg_cmd.shift) begin
      stage <= word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      settings   <= '0;
      set_strobe <= 1'b0;
    end else begin
      set_strobe <= cfg_cmd.shift && cfg_cmd.last;
      if (cfg_cmd.shift && cfg_cmd.last) begin
        case (cfg_cmd.setting)
          SET_TRIGGER:       settings.trigger       <= word;
          SET_TRIGGER_MASK:  settings.trigger_mask  <= word;
          SET_TRIGGER_AFTER: settings.trigger_after <= word;
          SET_TRIGGER_EDGE:  settings.trigger_edge  <= word;
          SET_BOTH_EDGES:    settings.both_edges    <= word;
          SET_REPEAT_COUNT:  settings.repeat_count  <= word;
          default: begin
          end
        endcase
      end
    end
  end

  // disable wins over a write in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      enable <= 1'b0;
    end else if (disable_uart || cfg_cmd.clear_enable) begin
      enable <= 1'b0;
    end else if (cfg_cmd.write_enable) begin
      enable <= cfg_cmd.enable_value;
    end
  end

  a_set_strobe_pulse: assert property (@(posedge clk) disable iff (rst)
    set_strobe |=> !set_strobe);

endmodule

//--- parser/la_frame_parser.sv
// host command frame parser

module la_frame_parser (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          rx_strobe,
  input  logic [7:0]                    rx_data,
  input  logic                          enable,
  input  logic                          resp_done,
  output la_config_pkg::la_config_cmd_t cfg_cmd,
  output logic                          resp_start,
  output la_protocol_pkg::la_response_t resp
);
  import la_protocol_pkg::*;
  import la_config_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ_CMD,
    ST_READ_HEX,
    ST_READ_ENABLE,
    ST_AWAIT_LF,
    ST_SEND
  } parse_state_e;

  parse_state_e                          state;
  la_setting_e                           setting_sel;
  logic [$clog2(NIBBLES_PER_WORD)-1:0]   digit_cnt;
  logic                                  resp_pending;
  logic                                  early_lf;

  // ascii hex to nibble, uppercase letters only
  function automatic logic [3:0] hex_to_nibble(input logic [7:0] c);
    logic [7:0] v;
    v = (c >= 8'h41) ? (c - 8'h37) : (c - 8'h30);
    return v[3:0];
  endfunction

  function automatic la_setting_e letter_to_setting(input logic [7:0] c);
    la_setting_e s;
    case (c)
      CMD_WRITE_MASK:          s = SET_TRIGGER_MASK;
      CMD_WRITE_TRIGGER_AFTER: s = SET_TRIGGER_AFTER;
      CMD_WRITE_TRIGGER_EDGE:  s = SET_TRIGGER_EDGE;
      CMD_WRITE_BOTH_EDGES:    s = SET_BOTH_EDGES;
      CMD_WRITE_REPEAT_COUNT:  s = SET_REPEAT_COUNT;
      default:                 s = SET_TRIGGER;
    endcase
    return s;
  endfunction

  // line feed ends any frame that is not waiting for it
  assign early_lf = rx_strobe && (rx_data == LINE_FEED) &&
                    !(state inside {ST_AWAIT_LF, ST_SEND});

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= ST_IDLE;
      setting_sel  <= SET_TRIGGER;
      digit_cnt    <= '0;
      cfg_cmd      <= '0;
      resp_start   <= 1'b0;
      resp_pending <= 1'b0;
    end else begin
      cfg_cmd.shift        <= 1'b0;
      cfg_cmd.write_enable <= 1'b0;
      cfg_cmd.clear_enable <= 1'b0;
      resp_start           <= 1'b0;

      if (early_lf) begin
        state <= ST_IDLE;
      end else begin
        case (state)
          ST_IDLE: begin
            if (rx_strobe && rx_data == START_ID) begin
              state <= ST_READ_CMD;
            end
          end
          ST_READ_CMD: begin
            if (rx_strobe) begin
              resp.has_arg <= 1'b0;
              case (rx_data)
                CMD_PING: begin
                  resp.status <= RESPONSE_SUCCESS;
                  state       <= ST_AWAIT_LF;
                end
                CMD_WRITE_TRIGGER, CMD_WRITE_MASK, CMD_WRITE_TRIGGER_AFTER,
                CMD_WRITE_TRIGGER_EDGE, CMD_WRITE_BOTH_EDGES,
                CMD_WRITE_REPEAT_COUNT: begin
                  // analyzer stops while its settings change
                  cfg_cmd.clear_enable <= 1'b1;
                  setting_sel          <= letter_to_setting(rx_data);
                  digit_cnt            <= '0;
                  state                <= ST_READ_HEX;
                end
                CMD_SET_ENABLE: begin
                  state <= ST_READ_ENABLE;
                end
                CMD_GET_ENABLE: begin
                  resp.status  <= RESPONSE_SUCCESS;
                  resp.has_arg <= 1'b1;
                  resp.arg     <= HEX_0 + {7'b0, enable};
                  state        <= ST_AWAIT_LF;
                end
                default: begin
                  resp.status <= RESPONSE_FAIL;
                  state       <= ST_AWAIT_LF;
                end
              endcase
            end
          end
          ST_READ_HEX: begin
            if (rx_strobe) begin
              cfg_cmd.shift   <= 1'b1;
              cfg_cmd.setting <= setting_sel;
              cfg_cmd.nibble  <= hex_to_nibble(rx_data);
              cfg_cmd.last    <= (int'(digit_cnt) == NIBBLES_PER_WORD - 1);
              digit_cnt       <= digit_cnt + 1'b1;
              if (int'(digit_cnt) == NIBBLES_PER_WORD - 1) begin
                resp.status  <= RESPONSE_SUCCESS;
                resp.has_arg <= 1'b0;
                state        <= ST_AWAIT_LF;
              end
            end
          end
          ST_READ_ENABLE: begin
            if (rx_strobe) begin
              resp.has_arg <= 1'b0;
              if (rx_data == HEX_0 || rx_data == HEX_0 + 8'd1) begin
                cfg_cmd.write_enable <= 1'b1;
                cfg_cmd.enable_value <= rx_data[0];
                resp.status          <= RESPONSE_SUCCESS;
              end else begin
                resp.status <= RESPONSE_FAIL;
              end
              state <= ST_AWAIT_LF;
            end
          end
          ST_AWAIT_LF: begin
            // anything but the line feed is dropped here
            if (rx_strobe && rx_data == LINE_FEED) begin
              state <= ST_SEND;
            end
          end
          ST_SEND: begin
            if (!resp_pending) begin
              resp_start   <= 1'b1;
              resp_pending <= 1'b1;
            end
            if (resp_done) begin
              resp_pending <= 1'b0;
              state        <= ST_IDLE;
            end
          end
          default: begin
            state <= ST_IDLE;
          end
        endcase
      end
    end
  end

  // one request at a time until the writer reports the line feed
  a_single_request: assert property (@(posedge clk) disable iff (rst)
    resp_start |=> (!resp_start until resp_done));

endmodule

//--- common/la_config_pkg.sv
// analyzer settings definitions

package la_config_pkg;

  localparam int CFG_WIDTH        = 32;
  localparam int NIBBLES_PER_WORD = 8;

  typedef enum logic [2:0] {
    SET_TRIGGER,
    SET_TRIGGER_MASK,
    SET_TRIGGER_AFTER,
    SET_TRIGGER_EDGE,
    SET_BOTH_EDGES,
    SET_REPEAT_COUNT
  } la_setting_e;

  typedef struct packed {
    logic [CFG_WIDTH-1:0] trigger;
    logic [CFG_WIDTH-1:0] trigger_mask;
    logic [CFG_WIDTH-1:0] trigger_after;
    logic [CFG_WIDTH-1:0] trigger_edge;
    logic [CFG_WIDTH-1:0] both_edges;
    logic [CFG_WIDTH-1:0] repeat_count;
  } la_config_t;

  // strobe fields are single cycle pulses
  typedef struct packed {
    logic        shift;
    la_setting_e setting;
    logic [3:0]  nibble;
    logic        last;
    logic        write_enable;
    logic        enable_value;
    logic        clear_enable;
  } la_config_cmd_t;

endpackage

//--- common/la_protocol_pkg.sv
// host link protocol definitions

package la_protocol_pkg;

  // frame bytes
  localparam logic [7:0] START_ID        = 8'h4C;  // "L"
  localparam logic [7:0] RESPONSE_ID     = 8'h53;  // "S"
  localparam logic [7:0] LINE_FEED       = 8'h0A;
  localparam logic [7:0] CARRIAGE_RETURN = 8'h0D;
  localparam logic [7:0] HEX_0           = 8'h30;  // "0"

  // command letters
  localparam logic [7:0] CMD_PING                = 8'h50;  // "P"
  localparam logic [7:0] CMD_WRITE_TRIGGER       = 8'h54;  // "T"
  localparam logic [7:0] CMD_WRITE_MASK          = 8'h4D;  // "M"
  localparam logic [7:0] CMD_WRITE_TRIGGER_AFTER = 8'h41;  // "A"
  localparam logic [7:0] CMD_WRITE_TRIGGER_EDGE  = 8'h45;  // "E"
  localparam logic [7:0] CMD_WRITE_BOTH_EDGES    = 8'h42;  // "B"
  localparam logic [7:0] CMD_WRITE_REPEAT_COUNT  = 8'h52;  // "R"
  localparam logic [7:0] CMD_SET_ENABLE          = 8'h4E;  // "N"
  localparam logic [7:0] CMD_GET_ENABLE          = 8'h47;  // "G"

  // status byte of a response
  localparam logic [7:0] RESPONSE_SUCCESS = 8'h4F;  // "O"
  localparam logic [7:0] RESPONSE_FAIL    = 8'h46;  // "F"

  // one response frame, from parser to writer
  typedef struct packed {
    logic [7:0] status;
    logic       has_arg;  // arg byte goes out between status and CR
    logic [7:0] arg;
  } la_response_t;

endpackage
